//--- verilog/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // control FSM states
    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_mem_wait,
        st_writeback,
        st_halt
    } state_e;

    // pass_b carries the U immediate for lui
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [3:0] {
        cls_alu_reg,
        cls_alu_imm,
        cls_lui,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_illegal
    } inst_class_e;

    typedef struct packed {
        inst_class_e           cls;
        alu_op_e               alu_op;
        logic [2:0]            br_funct3;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       imm;
    } decoded_t;

    // memory ports, one request pulse then one done pulse
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic            done;
        logic [xlen-1:0] data;
    } imem_rsp_t;

    typedef struct packed {
        logic            valid;
        logic            write;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic            done;
        logic [xlen-1:0] rdata;
    } dmem_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wdata;
        logic [xlen-1:0]       next_pc;
    } retire_t;

endpackage

//--- verilog/reg_file.sv
module reg_file (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] rd,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs2,
    input  logic [cpu_pkg::xlen-1:0]       wdata,
    output logic [cpu_pkg::xlen-1:0]       rs1_data,
    output logic [cpu_pkg::xlen-1:0]       rs2_data
);
    import cpu_pkg::*;

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [num_regs];

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // asynchronous read ports
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- verilog/fetch_unit.sv
module fetch_unit #(
    parameter logic [cpu_pkg::xlen-1:0] RESET_PC = '0
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  logic                     pc_load,
    input  logic [cpu_pkg::xlen-1:0] next_pc,
    output cpu_pkg::imem_req_t       imem_req,
    input  cpu_pkg::imem_rsp_t       imem_rsp,
    output logic [cpu_pkg::xlen-1:0] pc,
    output logic [cpu_pkg::xlen-1:0] inst,
    output logic                     fetched
);
    import cpu_pkg::*;

    logic            req_valid;
    logic [xlen-1:0] req_addr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc        <= RESET_PC;
            req_valid <= 1'b0;
            fetched   <= 1'b0;
        end else begin
            req_valid <= start;
            fetched   <= imem_rsp.done;
            if (pc_load) begin
                pc <= next_pc;
            end
        end
    end

    // request address and instruction word
    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= {pc[xlen-1:2], 2'b00};
        end
        if (imem_rsp.done) begin
            inst <= imem_rsp.data;
        end
    end

    assign imem_req = '{valid: req_valid, addr: req_addr};

endmodule

//--- verilog/decoder.sv
module decoder (
    input  logic [cpu_pkg::xlen-1:0] inst,
    output cpu_pkg::decoded_t        dec
);
    import cpu_pkg::*;

    // major opcodes of the kept subset
    typedef enum logic [6:0] {
        opc_reg    = 7'b0110011,
        opc_imm    = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_e;

    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    alu_op_e         arith_op;
    logic            f7_ok;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 to ALU op, bit 30 picks sub and sra
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (inst[30] && inst[6:0] == opc_reg) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = inst[30] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    // funct7 may only be 0100000 for sub and sra, otherwise all zero
    always_comb begin
        if (funct7 == 7'b0000000) begin
            f7_ok = 1'b1;
        end else if (funct7 == 7'b0100000) begin
            f7_ok = (funct3 == 3'b101) || (funct3 == 3'b000 && inst[6:0] == opc_reg);
        end else begin
            f7_ok = 1'b0;
        end
    end

    always_comb begin
        dec.cls       = cls_illegal;
        dec.alu_op    = alu_add;
        dec.br_funct3 = funct3;
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.rd        = inst[11:7];
        dec.imm       = imm_i;
        case (opcode_e'(inst[6:0]))
            opc_reg: begin
                dec.cls    = f7_ok ? cls_alu_reg : cls_illegal;
                dec.alu_op = arith_op;
            end
            opc_imm: begin
                // only the shifts carry a funct7 field
                dec.cls    = (funct3 == 3'b001 || funct3 == 3'b101) && !f7_ok ?
                             cls_illegal : cls_alu_imm;
                dec.alu_op = arith_op;
            end
            opc_lui: begin
                dec.cls    = cls_lui;
                dec.alu_op = alu_pass_b;
                dec.imm    = imm_u;
            end
            opc_load: begin
                dec.cls = (funct3 == 3'b010) ? cls_load : cls_illegal;
            end
            opc_store: begin
                dec.cls = (funct3 == 3'b010) ? cls_store : cls_illegal;
                dec.imm = imm_s;
            end
            opc_branch: begin
                dec.cls    = (funct3[2:1] == 2'b01) ? cls_illegal : cls_branch;
                dec.alu_op = alu_sub;
                dec.imm    = imm_b;
            end
            opc_jal: begin
                dec.cls = cls_jal;
                dec.imm = imm_j;
            end
            opc_jalr: begin
                dec.cls = (funct3 == 3'b000) ? cls_jalr : cls_illegal;
            end
            default: begin
                dec.cls = cls_illegal;
            end
        endcase
    end

endmodule

//--- verilog/alu.sv
module alu (
    input  cpu_pkg::alu_op_e         op,
    input  logic [cpu_pkg::xlen-1:0] a,
    input  logic [cpu_pkg::xlen-1:0] b,
    input  logic [2:0]               branch_funct3,
    output logic [cpu_pkg::xlen-1:0] result,
    output logic                     taken
);
    import cpu_pkg::*;

    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_sll:  result = a << b[4:0];
            alu_srl:  result = a >> b[4:0];
            alu_sra:  result = $unsigned($signed(a) >>> b[4:0]);
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_u};
            default:  result = b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (branch_funct3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = lt_s;
            3'b101:  taken = !lt_s;
            3'b110:  taken = lt_u;
            3'b111:  taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- verilog/load_store_unit.sv
module load_store_unit (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     go,
    input  logic                     write,
    input  logic [cpu_pkg::xlen-1:0] addr,
    input  logic [cpu_pkg::xlen-1:0] wdata,
    output cpu_pkg::dmem_req_t       dmem_req,
    input  cpu_pkg::dmem_rsp_t       dmem_rsp,
    output logic [cpu_pkg::xlen-1:0] rdata,
    output logic                     done
);
    import cpu_pkg::*;

    logic            req_valid;
    logic            req_write;
    logic [xlen-1:0] req_addr;
    logic [xlen-1:0] req_wdata;

    // one request pulse per go, one done pulse per memory done
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            req_valid <= go;
            done      <= dmem_rsp.done;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            req_write <= write;
            req_addr  <= {addr[xlen-1:2], 2'b00};
            req_wdata <= wdata;
        end
        // a store done carries no data, the value is simply not used
        if (dmem_rsp.done) begin
            rdata <= dmem_rsp.rdata;
        end
    end

    assign dmem_req = '{
        valid: req_valid,
        write: req_write,
        addr:  req_addr,
        wdata: req_wdata
    };

endmodule

//--- verilog/cpu.sv
module cpu #(
    parameter logic [cpu_pkg::xlen-1:0] RESET_PC = '0
) (
    input  logic               clk,
    input  logic               rstn,
    output cpu_pkg::imem_req_t imem_req,
    input  cpu_pkg::imem_rsp_t imem_rsp,
    output cpu_pkg::dmem_req_t dmem_req,
    input  cpu_pkg::dmem_rsp_t dmem_rsp,
    output cpu_pkg::retire_t   retire,
    output logic               halted
);
    import cpu_pkg::*;

    state_e          state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    logic            fetched;
    decoded_t        dec;
    decoded_t        dec_q;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] rs1_q;
    logic [xlen-1:0] rs2_q;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic            taken;
    logic            is_mem;
    logic            lsu_done;
    logic [xlen-1:0] lsu_rdata;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;
    logic            exe_we;
    logic [xlen-1:0] exe_data;
    logic [xlen-1:0] exe_next_pc;
    logic            wb_we;
    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] wb_next_pc;

    reg_file u_reg_file (
        .clk      (clk),
        .rstn     (rstn),
        .we       (state == st_writeback && wb_we),
        .rd       (dec_q.rd),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk      (clk),
        .rstn     (rstn),
        .start    (state == st_fetch),
        .pc_load  (state == st_writeback),
        .next_pc  (wb_next_pc),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .pc       (pc),
        .inst     (inst),
        .fetched  (fetched)
    );

    decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    alu u_alu (
        .op            (dec_q.alu_op),
        .a             (rs1_q),
        .b             (alu_b),
        .branch_funct3 (dec_q.br_funct3),
        .result        (alu_result),
        .taken         (taken)
    );

    load_store_unit u_lsu (
        .clk      (clk),
        .rstn     (rstn),
        .go       (state == st_execute && is_mem),
        .write    (dec_q.cls == cls_store),
        .addr     (alu_result),
        .wdata    (rs2_q),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp),
        .rdata    (lsu_rdata),
        .done     (lsu_done)
    );

    assign is_mem    = (dec_q.cls == cls_load) || (dec_q.cls == cls_store);
    assign alu_b     = (dec_q.cls == cls_alu_reg || dec_q.cls == cls_branch) ? rs2_q : dec_q.imm;
    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + dec_q.imm;

    // execute result and next pc selection
    always_comb begin
        exe_we      = 1'b0;
        exe_data    = alu_result;
        exe_next_pc = pc_plus4;
        case (dec_q.cls)
            cls_alu_reg, cls_alu_imm, cls_lui, cls_load: begin
                exe_we = 1'b1;
            end
            cls_branch: begin
                exe_next_pc = taken ? pc_target : pc_plus4;
            end
            cls_jal: begin
                exe_we      = 1'b1;
                exe_data    = pc_plus4;
                exe_next_pc = pc_target;
            end
            cls_jalr: begin
                exe_we      = 1'b1;
                exe_data    = pc_plus4;
                exe_next_pc = alu_result & ~32'd1;
            end
            default: begin
                exe_we = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_fetch;
        end else begin
            case (state)
                st_fetch:      state <= st_fetch_wait;
                st_fetch_wait: state <= fetched ? st_decode : st_fetch_wait;
                st_decode:     state <= st_execute;
                st_execute: begin
                    if (dec_q.cls == cls_illegal) begin
                        state <= st_halt;
                    end else if (is_mem) begin
                        state <= st_mem_wait;
                    end else begin
                        state <= st_writeback;
                    end
                end
                st_mem_wait:   state <= lsu_done ? st_writeback : st_mem_wait;
                st_writeback:  state <= st_fetch;
                default:       state <= st_halt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            dec_q <= dec;
            rs1_q <= rs1_data;
            rs2_q <= rs2_data;
        end
        if (state == st_execute) begin
            wb_we      <= exe_we && dec_q.rd != '0;
            wb_data    <= exe_data;
            // word-aligned, as the fetch path expects
            wb_next_pc <= {exe_next_pc[xlen-1:2], 2'b00};
        end
        if (state == st_mem_wait && lsu_done && dec_q.cls == cls_load) begin
            wb_data <= lsu_rdata;
        end
    end

    // rd and wdata read as zero when nothing is written
    assign retire = '{
        valid:   state == st_writeback,
        pc:      pc,
        we:      wb_we,
        rd:      wb_we ? dec_q.rd : '0,
        wdata:   wb_we ? wb_data : '0,
        next_pc: wb_next_pc
    };

    assign halted = (state == st_halt);

endmodule

//--- tb/cpu_props.sv
module cpu_props (
    input logic               clk,
    input logic               rstn,
    input cpu_pkg::state_e    state,
    input cpu_pkg::imem_req_t imem_req,
    input cpu_pkg::imem_rsp_t imem_rsp,
    input cpu_pkg::dmem_req_t dmem_req,
    input cpu_pkg::retire_t   retire,
    input logic               halted
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    // high from an instruction request until its done
    logic fetch_open;

    always @(posedge clk) begin
        if (!rstn) begin
            fetch_open <= 1'b0;
        end else if (imem_req.valid) begin
            fetch_open <= 1'b1;
        end else if (imem_rsp.done) begin
            fetch_open <= 1'b0;
        end
    end

    a_imem_pulse: assert property (@(posedge clk) disable iff (!rstn)
        imem_req.valid |=> !imem_req.valid)
        else $error("instruction request valid longer than one cycle");

    a_dmem_pulse: assert property (@(posedge clk) disable iff (!rstn)
        dmem_req.valid |=> !dmem_req.valid)
        else $error("data request valid longer than one cycle");

    // the request goes out in the first cycle of the wait for it
    a_one_fetch: assert property (@(posedge clk) disable iff (!rstn)
        imem_req.valid |-> (!fetch_open && state == st_fetch_wait))
        else $error("instruction request issued before the previous done");

    a_rd_nonzero: assert property (@(posedge clk) disable iff (!rstn)
        (retire.valid && retire.we) |-> retire.rd != '0)
        else $error("retire writes register zero");

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rstn)
        halted |=> (halted && !imem_req.valid && !dmem_req.valid && !retire.valid))
        else $error("core left the halt state or was active while halted");

endmodule

bind cpu cpu_props u_props (
    .clk      (clk),
    .rstn     (rstn),
    .state    (state),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp),
    .dmem_req (dmem_req),
    .retire   (retire),
    .halted   (halted)
);

//--- tb/tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam logic [31:0] reset_pc   = 32'h100;
    localparam logic [31:0] data_base  = 32'h600;
    localparam int          prog_len   = 256;
    localparam int          data_words = 64;
    localparam int          max_cycles = 2000 * 20;
    localparam logic [2:0]  br_f3 [6]  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    logic      clk      = 1'b0;
    logic      rstn     = 1'b0;
    imem_rsp_t imem_rsp = '0;
    dmem_rsp_t dmem_rsp = '0;
    imem_req_t imem_req;
    dmem_req_t dmem_req;
    retire_t   retire;
    logic      halted;

    integer seed = 32'h17d0458c;

    // program image and the fields it was built from
    logic [31:0] imem  [512];
    inst_class_e p_cls [512];
    alu_op_e     p_op  [512];
    logic [2:0]  p_f3  [512];
    logic [4:0]  p_rd  [512];
    logic [4:0]  p_rs1 [512];
    logic [4:0]  p_rs2 [512];
    logic [31:0] p_imm [512];

    logic [31:0] dmem       [data_words];
    logic [31:0] model_mem  [data_words];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    int          fetch_count;
    int          retire_count;
    int          store_count;
    int          checked_stores;
    dmem_req_t   store_got;
    int          imem_wait;
    logic [31:0] imem_addr;
    int          dmem_wait;
    logic [31:0] dmem_addr;
    logic        dmem_write;
    int          cycles = 0;

    cpu #(
        .RESET_PC (reset_pc)
    ) dut (
        .clk      (clk),
        .rstn     (rstn),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp),
        .retire   (retire),
        .halted   (halted)
    );

    always #5 clk = ~clk;

    task automatic end_in_failure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic report_mismatch(string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        end_in_failure();
    endtask

    task automatic report_problem(string msg);
        $display("%s", msg);
        end_in_failure();
    endtask

    task automatic check_retire(retire_t got, retire_t exp);
        if (got !== exp) begin
            report_mismatch({
                $sformatf("retire got pc %h we %0b rd %0d wdata %h next %h",
                    got.pc, got.we, got.rd, got.wdata, got.next_pc),
                $sformatf(", exp pc %h we %0b rd %0d wdata %h next %h",
                    exp.pc, exp.we, exp.rd, exp.wdata, exp.next_pc)});
        end
    endtask

    task automatic check_store(dmem_req_t got, dmem_req_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("store got addr %h data %h, expected addr %h data %h",
                got.addr, got.wdata, exp.addr, exp.wdata));
        end
    endtask

    task automatic check_fetch(imem_req_t got, imem_req_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("fetch got addr %h, expected addr %h", got.addr, exp.addr));
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], 16'hc3a5};
    endfunction

    function automatic logic [5:0] data_index(logic [31:0] addr);
        return addr[7:2];
    endfunction

    // {funct7, funct3} of each ALU operation
    function automatic logic [9:0] funct_bits(alu_op_e op);
        case (op)
            alu_sub:  return {7'b0100000, 3'b000};
            alu_sll:  return {7'b0000000, 3'b001};
            alu_slt:  return {7'b0000000, 3'b010};
            alu_sltu: return {7'b0000000, 3'b011};
            alu_xor:  return {7'b0000000, 3'b100};
            alu_srl:  return {7'b0000000, 3'b101};
            alu_sra:  return {7'b0100000, 3'b101};
            alu_or:   return {7'b0000000, 3'b110};
            alu_and:  return {7'b0000000, 3'b111};
            default:  return {7'b0000000, 3'b000};
        endcase
    endfunction

    function automatic logic [31:0] model_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $unsigned($signed(a) >>> b[4:0]);
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            default:  return b;
        endcase
    endfunction

    function automatic logic model_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        if (addr >= reset_pc && addr <= reset_pc + 32'(4 * prog_len)) begin
            return imem[9'((addr - reset_pc) >> 2)];
        end
        return 32'h0;
    endfunction

    // x7 holds the data base
    // targets only jump forward so the program ends
    task automatic build_program();
        logic [31:0] r;
        logic [31:0] off;
        logic [9:0]  fb;
        logic [11:0] imm12;
        int          choice;
        int          t;
        for (int k = 0; k <= prog_len; k++) begin
            p_cls[k] = cls_illegal;
            p_op[k]  = alu_add;
            p_f3[k]  = 3'b000;
            p_rd[k]  = 5'(rand_word() % 7);
            p_rs1[k] = 5'(rand_word() % 8);
            p_rs2[k] = 5'(rand_word() % 8);
            p_imm[k] = '0;
            imem[k]  = 32'h0;
        end
        p_cls[0] = cls_alu_imm;
        p_rd[0]  = 5'd7;
        p_rs1[0] = 5'd0;
        p_imm[0] = data_base;
        imem[0]  = {data_base[11:0], 5'd0, 3'b000, 5'd7, 7'b0010011};
        for (int k = 1; k < prog_len; k++) begin
            r      = rand_word();
            choice = int'(rand_word() % 16);
            t      = k + 1 + int'(rand_word() % 8);
            if (t > prog_len) begin
                t = prog_len;
            end
            off = 32'((t - k) * 4);
            if (choice <= 7) begin
                p_op[k] = alu_op_e'(4'(rand_word() % 10));
                if (choice >= 5 && p_op[k] == alu_sub) begin
                    p_op[k] = alu_add;
                end
                fb = funct_bits(p_op[k]);
            end
            if (choice <= 4) begin
                p_cls[k] = cls_alu_reg;
                imem[k]  = {fb[9:3], p_rs2[k], p_rs1[k], fb[2:0], p_rd[k], 7'b0110011};
            end else if (choice <= 7) begin
                p_cls[k] = cls_alu_imm;
                if (p_op[k] inside {alu_sll, alu_srl, alu_sra}) begin
                    imm12    = {fb[9:3], r[4:0]};
                    p_imm[k] = {27'b0, r[4:0]};
                end else begin
                    imm12    = r[11:0];
                    p_imm[k] = {{20{r[11]}}, r[11:0]};
                end
                imem[k] = {imm12, p_rs1[k], fb[2:0], p_rd[k], 7'b0010011};
            end else if (choice == 8) begin
                p_cls[k] = cls_lui;
                p_imm[k] = {r[31:12], 12'b0};
                imem[k]  = {r[31:12], p_rd[k], 7'b0110111};
            end else if (choice <= 12) begin
                p_cls[k] = (choice <= 10) ? cls_load : cls_store;
                p_rs1[k] = 5'd7;
                p_imm[k] = {24'b0, r[5:0], 2'b00};
                if (choice <= 10) begin
                    imem[k] = {p_imm[k][11:0], 5'd7, 3'b010, p_rd[k], 7'b0000011};
                end else begin
                    imem[k] = {p_imm[k][11:5], p_rs2[k], 5'd7, 3'b010, p_imm[k][4:0],
                               7'b0100011};
                end
            end else if (choice == 13) begin
                p_cls[k] = cls_branch;
                p_f3[k]  = br_f3[r % 6];
                p_imm[k] = off;
                imem[k]  = {off[12], off[10:5], p_rs2[k], p_rs1[k], p_f3[k], off[4:1], off[11],
                            7'b1100011};
            end else if (choice == 14) begin
                p_cls[k] = cls_jal;
                p_imm[k] = off;
                imem[k]  = {off[20], off[10:1], off[11], off[19:12], p_rd[k], 7'b1101111};
            end else begin
                // absolute target relative to x7 with the low bit set now and then
                p_cls[k] = cls_jalr;
                p_rs1[k] = 5'd7;
                p_imm[k] = reset_pc + 32'(4 * t) - data_base + {31'b0, r[0]};
                imem[k]  = {p_imm[k][11:0], 5'd7, 3'b000, p_rd[k], 7'b1100111};
            end
        end
    endtask

    // executes the next instruction on each retire and compares
    task automatic model_retire(retire_t got);
        logic [8:0]  k;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] next;
        logic [31:0] addr;
        logic        writes;
        logic        wr;
        retire_t     exp;
        dmem_req_t   exp_st;
        k      = 9'((model_pc - reset_pc) >> 2);
        a      = model_regs[p_rs1[k]];
        b      = model_regs[p_rs2[k]];
        res    = '0;
        next   = model_pc + 32'd4;
        addr   = a + p_imm[k];
        writes = 1'b0;
        if (fetch_count != retire_count + 1) begin
            report_problem("retire without exactly one fetch request for it");
        end
        if (p_cls[k] == cls_illegal) begin
            report_problem("core retired the illegal instruction instead of halting");
        end
        case (p_cls[k])
            cls_alu_reg: res = model_alu(p_op[k], a, b);
            cls_alu_imm: res = model_alu(p_op[k], a, p_imm[k]);
            cls_lui:     res = p_imm[k];
            cls_load:    res = model_mem[data_index(addr)];
            cls_branch:  next = model_taken(p_f3[k], a, b) ? model_pc + p_imm[k] : next;
            cls_jal: begin
                res  = model_pc + 32'd4;
                next = model_pc + p_imm[k];
            end
            cls_jalr: begin
                res  = model_pc + 32'd4;
                next = addr & ~32'd1;
            end
            default: res = '0;
        endcase
        writes = p_cls[k] inside {cls_alu_reg, cls_alu_imm, cls_lui, cls_load, cls_jal, cls_jalr};
        wr     = writes && p_rd[k] != 5'd0;
        exp    = '{valid: 1'b1, pc: model_pc, we: wr, rd: wr ? p_rd[k] : 5'd0,
                   wdata: wr ? res : 32'h0, next_pc: next & ~32'd3};
        check_retire(got, exp);
        if (p_cls[k] == cls_store) begin
            if (store_count != checked_stores + 1) begin
                report_problem("store retired without exactly one data write");
            end
            exp_st = '{valid: 1'b1, write: 1'b1, addr: addr & ~32'd3, wdata: b};
            check_store(store_got, exp_st);
            checked_stores = checked_stores + 1;
            model_mem[data_index(addr)] = b;
        end else if (store_count != checked_stores) begin
            report_problem("data write from an instruction that is not a store");
        end
        if (wr) begin
            model_regs[p_rd[k]] = res;
        end
        model_pc     = next & ~32'd3;
        retire_count = retire_count + 1;
    endtask

    // instruction memory with 1 to 4 cycles of latency
    always @(posedge clk) begin
        imem_rsp <= '0;
        if (!rstn) begin
            imem_wait   <= 0;
            fetch_count = 0;
        end else if (imem_req.valid) begin
            if (fetch_count != retire_count) begin
                report_problem("new fetch before the previous instruction retired");
            end
            check_fetch(imem_req, '{valid: 1'b1, addr: model_pc});
            fetch_count = fetch_count + 1;
            imem_addr <= imem_req.addr;
            imem_wait <= 1 + int'(rand_word() % 4);
        end else if (imem_wait == 1) begin
            imem_rsp  <= '{done: 1'b1, data: fetch_word(imem_addr)};
            imem_wait <= 0;
        end else if (imem_wait > 1) begin
            imem_wait <= imem_wait - 1;
        end
    end

    // data memory writes stores when they are requested
    always @(posedge clk) begin
        dmem_rsp <= '0;
        if (!rstn) begin
            dmem_wait   <= 0;
            store_count = 0;
            for (int i = 0; i < data_words; i++) begin
                dmem[i] <= fill_word(data_base + 32'(4 * i));
            end
        end else if (dmem_req.valid) begin
            if (fetch_count == 0) begin
                report_problem("data request before the first fetch");
            end
            if (dmem_req.addr[31:8] != data_base[31:8]) begin
                report_problem($sformatf("data access outside the data region at %h",
                    dmem_req.addr));
            end
            if (dmem_req.write) begin
                dmem[data_index(dmem_req.addr)] <= dmem_req.wdata;
                store_got   = dmem_req;
                store_count = store_count + 1;
            end
            dmem_addr  <= dmem_req.addr;
            dmem_write <= dmem_req.write;
            dmem_wait  <= 1 + int'(rand_word() % 4);
        end else if (dmem_wait == 1) begin
            dmem_rsp  <= '{done: 1'b1, rdata: dmem_write ? 32'h0 : dmem[data_index(dmem_addr)]};
            dmem_wait <= 0;
        end else if (dmem_wait > 1) begin
            dmem_wait <= dmem_wait - 1;
        end
    end

    always @(posedge clk) begin
        if (!rstn) begin
            model_pc       = reset_pc;
            retire_count   = 0;
            checked_stores = 0;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            for (int i = 0; i < data_words; i++) begin
                model_mem[i] = fill_word(data_base + 32'(4 * i));
            end
        end else if (retire.valid) begin
            model_retire(retire);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            report_problem($sformatf("core hung, no halt after %0d cycles", cycles));
        end
    end

    initial begin
        build_program();
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        while (halted !== 1'b1) begin
            @(posedge clk);
        end
        // retires after the halt would still be caught here
        repeat (20) @(posedge clk);
        if (model_pc == reset_pc + 32'(4 * prog_len) && fetch_count == retire_count + 1) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_problem($sformatf("halted after %0d retires with the model at pc %h",
                retire_count, model_pc));
        end
    end

endmodule

//--- flist.f
verilog/cpu_pkg.sv
verilog/reg_file.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/alu.sv
verilog/load_store_unit.sv
verilog/cpu.sv
tb/cpu_props.sv
tb/tb_cpu.sv

//--- Makefile
TOP := tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
